/* pipe_config.svh */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// ----------------------------------------------------------------------
// Pipeline control sizing
// ----------------------------------------------------------------------

// Register number width, r0..r31
`define REG_ADDR_W 5

`define LINK_REG 31   // Return address register written by JAL

// Performance counter width
`define COUNT_W 16

`endif

/* mipsIsaPkg.sv */
`default_nettype none

`include "pipe_config.svh"

package mipsIsaPkg;

    // ------------------------------------------------------------------
    // Primary opcodes
    // ------------------------------------------------------------------
    localparam logic [5:0] OP_SPECIAL = 6'b000000; // R-type, op in funct
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011; // Links into r31
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;

    // Immediate ALU group, rt is the destination
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // Loads
    localparam logic [5:0] OP_LB      = 6'b100000;
    localparam logic [5:0] OP_LH      = 6'b100001;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_LBU     = 6'b100100;
    localparam logic [5:0] OP_LHU     = 6'b100101;
    localparam logic [5:0] OP_LWU     = 6'b100111;

    // Stores, rt is read as data
    localparam logic [5:0] OP_SB      = 6'b101000;
    localparam logic [5:0] OP_SH      = 6'b101001;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // Function codes under OP_SPECIAL
    localparam logic [5:0] FN_JR      = 6'b001000;
    localparam logic [5:0] FN_JALR    = 6'b001001; // Links into rd

    // ------------------------------------------------------------------
    // Instruction word, two views of the same 32 bits
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } rTypeFmt;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;    // Offset or immediate operand
    } iTypeFmt;

    typedef union packed {
        rTypeFmt rType;
        iTypeFmt iType;
    } instrWord;

endpackage

`default_nettype wire

/* pipeCtrlPkg.sv */
`default_nettype none

package pipeCtrlPkg;

    // Where the destination register number comes from
    typedef enum logic [1:0] {
        DST_RT = 2'b00,     // Loads, immediate ALU ops
        DST_RD = 2'b01,     // R-type incl. JALR
        DST_RA = 2'b10      // JAL, fixed link register
    } dstSel;

    // Stall episode tracking
    typedef enum logic {
        RUN  = 1'b0,
        HOLD = 1'b1         // Previous cycle was a stall
    } hazState;

endpackage

`default_nettype wire

/* instrDecode.sv */
`default_nettype none

`include "pipe_config.svh"

module instrDecode (
    input  wire logic                   instrValid,
    input  wire mipsIsaPkg::instrWord   instr,
    output logic [`REG_ADDR_W-1:0]      rs,
    output logic [`REG_ADDR_W-1:0]      rt,
    output logic [`REG_ADDR_W-1:0]      dst,
    output pipeCtrlPkg::dstSel          dstKind,
    output logic                        isBranchCmp,
    output logic                        isLoad,
    output logic                        writesReg,
    output logic                        isJump,
    output logic                        isJr
);

    localparam logic [`REG_ADDR_W-1:0] linkReg = `LINK_REG;

    logic loadOp;       // Any load opcode
    logic writeClass;   // Opcode class that writes a register
    logic liveDst;      // Destination other than r0

    always_comb begin
        // Invalid word falls through as a NOP
        rs          = '0;
        rt          = '0;
        dst         = '0;
        dstKind     = pipeCtrlPkg::DST_RT;
        loadOp      = 1'b0;
        writeClass  = 1'b0;
        isBranchCmp = 1'b0;
        isJump      = 1'b0;
        isJr        = 1'b0;
        if (instrValid) begin
            if (instr.rType.opcode == mipsIsaPkg::OP_SPECIAL) begin
                rs      = instr.rType.rs;
                rt      = instr.rType.rt;
                dst     = instr.rType.rd;
                dstKind = pipeCtrlPkg::DST_RD;
                isJr    = (instr.rType.funct == mipsIsaPkg::FN_JR) ||
                          (instr.rType.funct == mipsIsaPkg::FN_JALR);
                writeClass = (instr.rType.funct != mipsIsaPkg::FN_JR); // JR links nothing
            end else begin
                rs = instr.iType.rs;
                rt = instr.iType.rt;
                case (instr.iType.opcode)
                    mipsIsaPkg::OP_BEQ, mipsIsaPkg::OP_BNE:
                        isBranchCmp = 1'b1;
                    mipsIsaPkg::OP_J:
                        isJump = 1'b1;
                    mipsIsaPkg::OP_JAL: begin
                        isJump     = 1'b1;
                        dst        = linkReg;
                        dstKind    = pipeCtrlPkg::DST_RA;
                        writeClass = 1'b1;
                    end
                    mipsIsaPkg::OP_LW, mipsIsaPkg::OP_LB, mipsIsaPkg::OP_LH,
                    mipsIsaPkg::OP_LBU, mipsIsaPkg::OP_LHU, mipsIsaPkg::OP_LWU: begin
                        loadOp     = 1'b1;
                        dst        = instr.iType.rt;
                        writeClass = 1'b1;
                    end
                    mipsIsaPkg::OP_ADDI, mipsIsaPkg::OP_ADDIU, mipsIsaPkg::OP_ANDI,
                    mipsIsaPkg::OP_ORI, mipsIsaPkg::OP_XORI, mipsIsaPkg::OP_LUI,
                    mipsIsaPkg::OP_SLTI, mipsIsaPkg::OP_SLTIU: begin
                        dst        = instr.iType.rt;
                        writeClass = 1'b1;
                    end
                    mipsIsaPkg::OP_SW, mipsIsaPkg::OP_SB, mipsIsaPkg::OP_SH:
                        writeClass = 1'b0;      // Store data in rt, no destination
                    default: ;                  // Unknown opcode, no hazard role
                endcase
            end
        end
    end

    // Writes to r0 never create a dependency
    assign liveDst   = (dst != '0);
    assign writesReg = writeClass && liveDst;
    assign isLoad    = loadOp && liveDst;

    // Jump register and compare branch come from disjoint opcodes
    jrNotBranch: assert final (!(isJr && isBranchCmp))
        else $error("isJr and isBranchCmp both high");

endmodule

`default_nettype wire

/* destTracker.sv */
`default_nettype none

`include "pipe_config.svh"

module destTracker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   advance,     // PC write, ID moves on
    input  wire logic                   bubble,      // Control stall
    input  wire logic [`REG_ADDR_W-1:0] dst,
    input  wire pipeCtrlPkg::dstSel     dstKind,
    input  wire logic                   writesReg,
    input  wire logic                   isLoad,
    output logic [`REG_ADDR_W-1:0]      idExRt,
    output logic [`REG_ADDR_W-1:0]      idExRd,
    output pipeCtrlPkg::dstSel          idExKind,
    output logic                        idExWrite,
    output logic                        idExMemRead,
    output logic [`REG_ADDR_W-1:0]      exMemDst,
    output logic                        exMemWrite
);

    logic [`REG_ADDR_W-1:0] idExDst;    // Destination of the EX instruction
    logic                   takeId;     // ID instruction enters EX

    assign takeId = advance && !bubble;

    // ------------------------------------------------------------------
    // Two-deep destination record, ID/EX then EX/MEM
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            idExDst     <= '0;
            idExKind    <= pipeCtrlPkg::DST_RT;
            idExWrite   <= 1'b0;
            idExMemRead <= 1'b0;
            exMemDst    <= '0;
            exMemWrite  <= 1'b0;
        end else begin
            if (takeId) begin
                idExDst     <= dst;
                idExKind    <= dstKind;
                idExWrite   <= writesReg;
                idExMemRead <= isLoad;
            end else begin               // Empty slot enters EX
                idExDst     <= '0;
                idExKind    <= pipeCtrlPkg::DST_RT;
                idExWrite   <= 1'b0;
                idExMemRead <= 1'b0;
            end
            exMemDst   <= idExDst;       // Older record always moves on
            exMemWrite <= idExWrite;
        end
    end

    // Field views as the datapath would see them in ID/EX
    assign idExRt = (idExKind == pipeCtrlPkg::DST_RT) ? idExDst : '0;
    assign idExRd = (idExKind == pipeCtrlPkg::DST_RT) ? '0 : idExDst;

    // Every load recorded in EX also writes its destination
    loadWrites: assert property (@(posedge clk) disable iff (reset)
        idExMemRead |-> idExWrite)
        else $error("ID/EX load without register write");

endmodule

`default_nettype wire

/* hazardFsm.sv */
`default_nettype none

`include "pipe_config.svh"

module hazardFsm (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [`REG_ADDR_W-1:0] rs,
    input  wire logic [`REG_ADDR_W-1:0] rt,
    input  wire logic                   isBranchCmp,
    input  wire logic                   isLoad,
    input  wire logic                   isJump,
    input  wire logic                   isJr,
    input  wire logic [`REG_ADDR_W-1:0] idExRt,
    input  wire logic [`REG_ADDR_W-1:0] idExRd,
    input  wire pipeCtrlPkg::dstSel     idExKind,
    input  wire logic                   idExWrite,
    input  wire logic                   idExMemRead,
    input  wire logic [`REG_ADDR_W-1:0] exMemDst,
    input  wire logic                   exMemWrite,
    input  wire logic [`REG_ADDR_W-1:0] memWbDst,
    output logic                        pcWrite,
    output logic                        ifIdWrite,
    output logic                        controlStall,
    output logic                        branchFlush,
    output logic                        compareReady,
    output logic                        stallStart   // First cycle of an episode
);

    localparam logic [`REG_ADDR_W-1:0] linkReg = `LINK_REG;

    pipeCtrlPkg::hazState   state;
    logic [`REG_ADDR_W-1:0] exDst;      // Selected EX destination
    logic                   exHitRs;
    logic                   exHitRt;
    logic                   memHitRs;
    logic                   branchHaz;  // Rule 1
    logic                   loadUse;    // Rule 3
    logic                   linkBusy;   // Rule 4
    logic                   jrSrcBusy;  // Rule 5

    // ------------------------------------------------------------------
    // Dependency checks
    // ------------------------------------------------------------------
    assign exDst    = (idExKind == pipeCtrlPkg::DST_RT) ? idExRt : idExRd;
    assign exHitRs  = idExWrite && (exDst == rs);
    assign exHitRt  = idExWrite && (exDst == rt);
    assign memHitRs = exMemWrite && (exMemDst == rs);

    assign branchHaz = isBranchCmp && (exHitRs || exHitRt);
    // A load in ID has rt as its destination, not a source
    assign loadUse   = idExMemRead && ((exDst == rs) || (!isLoad && (exDst == rt)));
    assign linkBusy  = isJr && ((idExWrite && (idExKind == pipeCtrlPkg::DST_RA)) ||
                                (exMemWrite && (exMemDst == linkReg)));
    assign jrSrcBusy = isJr && (exHitRs || memHitRs);

    // ------------------------------------------------------------------
    // Rules in priority order
    // ------------------------------------------------------------------
    always_comb begin
        pcWrite      = 1'b1;            // Default, pipeline flows
        ifIdWrite    = 1'b1;
        controlStall = 1'b0;
        branchFlush  = 1'b0;
        compareReady = 1'b0;
        if (branchHaz) begin
            pcWrite      = 1'b0;
            ifIdWrite    = 1'b0;
            controlStall = 1'b1;
            // Ready only if WB is not about to write a compared source
            compareReady = (memWbDst != rs) && (memWbDst != rt);
        end else if (isBranchCmp) begin
            compareReady = 1'b1;        // Operands clean, compare in ID
        end else if (loadUse) begin
            pcWrite      = 1'b0;
            ifIdWrite    = 1'b0;
            controlStall = 1'b1;
        end else if (linkBusy) begin
            pcWrite      = 1'b0;        // Return address still in flight
            ifIdWrite    = 1'b0;
            controlStall = 1'b1;
            branchFlush  = 1'b1;
        end else if (jrSrcBusy) begin
            pcWrite      = 1'b0;
            ifIdWrite    = 1'b0;
            controlStall = 1'b1;
        end else if (isJump || isJr) begin
            ifIdWrite    = 1'b0;        // Target fetched, slot squashed
            branchFlush  = 1'b1;
        end
    end

    // Episode state, HOLD after any stall cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pipeCtrlPkg::RUN;
        end else begin
            state <= controlStall ? pipeCtrlPkg::HOLD : pipeCtrlPkg::RUN;
        end
    end

    assign stallStart = (state == pipeCtrlPkg::RUN) && controlStall;

    stallFreezesPc: assert property (@(posedge clk) disable iff (reset)
        controlStall |-> !pcWrite)
        else $error("PC written during a control stall");

    // Tracker must turn every stall into an empty EX slot
    stallBubbles: assert property (@(posedge clk) disable iff (reset)
        controlStall |=> !idExWrite)
        else $error("No bubble in ID/EX after a stall");

endmodule

`default_nettype wire

/* stallCounter.sv */
`default_nettype none

`include "pipe_config.svh"

module stallCounter (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           stallStart,
    input  wire logic           branchFlush,
    input  wire logic           instrValid,
    output logic [`COUNT_W-1:0] stallCount,    // Stall episodes
    output logic [`COUNT_W-1:0] flushCount     // Flush cycles on valid words
);

    // Sticks at all ones
    function automatic logic [`COUNT_W-1:0] satInc(input logic [`COUNT_W-1:0] val);
        return (val == '1) ? val : val + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            stallCount <= '0;
            flushCount <= '0;
        end else begin
            if (stallStart) begin
                stallCount <= satInc(stallCount);
            end
            if (branchFlush && instrValid) begin
                flushCount <= satInc(flushCount);
            end
        end
    end

endmodule

`default_nettype wire

/* hazardTop.sv */
`default_nettype none

`include "pipe_config.svh"

module hazardTop (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   instrValid,
    input  wire mipsIsaPkg::instrWord   instr,       // IF/ID word
    input  wire logic [`REG_ADDR_W-1:0] memWbDst,
    output logic                        pcWrite,
    output logic                        ifIdWrite,
    output logic                        controlStall,
    output logic                        branchFlush,
    output logic                        compareReady,
    output logic [`COUNT_W-1:0]         stallCount,
    output logic [`COUNT_W-1:0]         flushCount
);

    // ID stage decode
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] dst;
    pipeCtrlPkg::dstSel     dstKind;
    logic                   isBranchCmp;
    logic                   isLoad;
    logic                   writesReg;
    logic                   isJump;
    logic                   isJr;

    // Destination records
    logic [`REG_ADDR_W-1:0] idExRt;
    logic [`REG_ADDR_W-1:0] idExRd;
    pipeCtrlPkg::dstSel     idExKind;
    logic                   idExWrite;
    logic                   idExMemRead;
    logic [`REG_ADDR_W-1:0] exMemDst;
    logic                   exMemWrite;

    logic                   stallStart;

    instrDecode decode0 (
        .instrValid  (instrValid),
        .instr       (instr),
        .rs          (rs),
        .rt          (rt),
        .dst         (dst),
        .dstKind     (dstKind),
        .isBranchCmp (isBranchCmp),
        .isLoad      (isLoad),
        .writesReg   (writesReg),
        .isJump      (isJump),
        .isJr        (isJr)
    );

    destTracker tracker0 (
        .clk         (clk),
        .reset       (reset),
        .advance     (pcWrite),
        .bubble      (controlStall),
        .dst         (dst),
        .dstKind     (dstKind),
        .writesReg   (writesReg),
        .isLoad      (isLoad),
        .idExRt      (idExRt),
        .idExRd      (idExRd),
        .idExKind    (idExKind),
        .idExWrite   (idExWrite),
        .idExMemRead (idExMemRead),
        .exMemDst    (exMemDst),
        .exMemWrite  (exMemWrite)
    );

    hazardFsm fsm0 (
        .clk          (clk),
        .reset        (reset),
        .rs           (rs),
        .rt           (rt),
        .isBranchCmp  (isBranchCmp),
        .isLoad       (isLoad),
        .isJump       (isJump),
        .isJr         (isJr),
        .idExRt       (idExRt),
        .idExRd       (idExRd),
        .idExKind     (idExKind),
        .idExWrite    (idExWrite),
        .idExMemRead  (idExMemRead),
        .exMemDst     (exMemDst),
        .exMemWrite   (exMemWrite),
        .memWbDst     (memWbDst),
        .pcWrite      (pcWrite),
        .ifIdWrite    (ifIdWrite),
        .controlStall (controlStall),
        .branchFlush  (branchFlush),
        .compareReady (compareReady),
        .stallStart   (stallStart)
    );

    stallCounter counter0 (
        .clk         (clk),
        .reset       (reset),
        .stallStart  (stallStart),
        .branchFlush (branchFlush),
        .instrValid  (instrValid),
        .stallCount  (stallCount),
        .flushCount  (flushCount)
    );

endmodule

`default_nettype wire

/* tbHazard.sv */
`default_nettype none

`include "pipe_config.svh"

module tbHazard;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;        // After the rising edge
    localparam int RESET_CYCLES = 3;
    localparam int MAX_HOLD     = 6;        // Longest legal hold of one word
    // Cycles per test from the reset check through the closing idle slot
    localparam int TEST_CYCLES  = 8 + 5 + 9 + 10 + 4 + 5;
    localparam int MARGIN       = 40;

    localparam logic [5:0] FN_ADD = 6'b100000;
    localparam mipsIsaPkg::instrWord NOP_WORD = '0;    // sll r0, r0, 0

    logic                   clk;
    logic                   reset;
    logic                   instrValid;
    mipsIsaPkg::instrWord   instr;
    logic [`REG_ADDR_W-1:0] memWbDst;
    logic                   pcWrite;
    logic                   ifIdWrite;
    logic                   controlStall;
    logic                   branchFlush;
    logic                   compareReady;
    logic [`COUNT_W-1:0]    stallCount;
    logic [`COUNT_W-1:0]    flushCount;

    string       testName;
    int          numTests;
    int          numChecks;
    int          numErrors;
    int          errorsAtStart;
    int          stallCycles;       // Per issued word
    int          flushCycles;
    logic        readyFirst;        // compareReady in the first ID cycle
    logic        readyLast;         // compareReady when the word left ID
    logic        ifIdLast;
    logic [31:0] rngState;

    hazardTop dut0 (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instr        (instr),
        .memWbDst     (memWbDst),
        .pcWrite      (pcWrite),
        .ifIdWrite    (ifIdWrite),
        .controlStall (controlStall),
        .branchFlush  (branchFlush),
        .compareReady (compareReady),
        .stallCount   (stallCount),
        .flushCount   (flushCount)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;    // LCG step
        return rngState;
    endfunction

    function automatic mipsIsaPkg::instrWord encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                                     input logic [4:0] rd, input logic [5:0] fn);
        mipsIsaPkg::instrWord w;
        w = '0;
        w.rType.opcode = mipsIsaPkg::OP_SPECIAL;
        w.rType.rs     = rs;
        w.rType.rt     = rt;
        w.rType.rd     = rd;
        w.rType.funct  = fn;
        return w;
    endfunction

    function automatic mipsIsaPkg::instrWord encodeI(input logic [5:0] op, input logic [4:0] rs,
                                                     input logic [4:0] rt, input logic [15:0] imm);
        mipsIsaPkg::instrWord w;
        w.iType.opcode = op;
        w.iType.rs     = rs;
        w.iType.rt     = rt;
        w.iType.imm    = imm;   // Jump target bits for J and JAL
        return w;
    endfunction

    task automatic checkBit(input string what, input logic expected, input logic actual);
        numChecks++;
        if (actual !== expected) begin
            numErrors++;
            $display("[ERROR] %s %s: expected %0b actual %0b", testName, what, expected, actual);
        end
    endtask

    task automatic checkCount(input string what, input logic [`COUNT_W-1:0] expected,
                              input logic [`COUNT_W-1:0] actual);
        numChecks++;
        if (actual !== expected) begin
            numErrors++;
            $display("[ERROR] %s %s: expected %0d actual %0d", testName, what, expected, actual);
        end
    endtask

    // Drives one word into ID and holds it until the PC moves on
    task automatic issue(input logic valid, input mipsIsaPkg::instrWord word,
                         input logic [`REG_ADDR_W-1:0] wbDst);
        int   holdCycles;
        logic accepted;
        holdCycles  = 0;
        accepted    = 1'b0;
        stallCycles = 0;
        flushCycles = 0;
        while (!accepted && holdCycles < MAX_HOLD) begin
            @(posedge clk);
            #DRIVE_DELAY;
            instrValid = valid;
            instr      = word;
            memWbDst   = wbDst;
            @(negedge clk);                     // Controls settled
            if (holdCycles == 0) readyFirst = compareReady;
            if (controlStall) begin
                stallCycles++;
                checkBit("pcWrite in stall", 1'b0, pcWrite);
                checkBit("ifIdWrite in stall", 1'b0, ifIdWrite);
            end
            if (branchFlush) flushCycles++;
            readyLast  = compareReady;
            ifIdLast   = ifIdWrite;
            accepted   = pcWrite;
            holdCycles++;
        end
        if (!accepted) begin
            numErrors++;
            $display("%s: word %h was still held in ID after %0d cycles",
                     testName, word, holdCycles);
        end
    endtask

    task automatic idleSlot();
        issue(1'b1, NOP_WORD, '0);  // Counters now include every earlier cycle
    endtask

    task automatic beginTest(input string name);
        testName      = name;
        errorsAtStart = numErrors;
        numTests++;
    endtask

    task automatic endTest();
        $display("%-10s %0d mismatch(es)", testName, numErrors - errorsAtStart);
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------
    task automatic resetAluTest();
        logic [4:0] srcA;
        logic [4:0] srcB;
        logic [4:0] dstReg;
        beginTest("resetAlu");
        @(negedge clk);
        checkBit("pcWrite", 1'b1, pcWrite);
        checkBit("ifIdWrite", 1'b1, ifIdWrite);
        checkBit("controlStall", 1'b0, controlStall);
        checkBit("branchFlush", 1'b0, branchFlush);
        checkBit("compareReady", 1'b0, compareReady);
        checkCount("stallCount", 0, stallCount);
        checkCount("flushCount", 0, flushCount);
        for (int i = 0; i < 6; i++) begin
            srcA   = 5'd1 + 5'(nextRand() % 32'd7);    // Sources r1..r7
            srcB   = 5'd1 + 5'(nextRand() % 32'd7);
            dstReg = 5'd16 + 5'(nextRand() % 32'd8);   // Dests r16..r23 are never read
            if (i % 2 == 0) begin
                issue(1'b1, encodeR(srcA, srcB, dstReg, FN_ADD), '0);
            end else begin
                issue(1'b1, encodeI(mipsIsaPkg::OP_ADDI, srcA, dstReg, 16'h0011), '0);
            end
            checkCount("stall cycles", 0, stallCycles);
            checkCount("flush cycles", 0, flushCycles);
        end
        idleSlot();
        checkCount("stallCount", 0, stallCount);
        checkCount("flushCount", 0, flushCount);
        endTest();
    endtask

    task automatic loadUseTest();
        logic [`COUNT_W-1:0] baseStall;
        beginTest("loadUse");
        idleSlot();
        baseStall = stallCount;
        issue(1'b1, encodeI(mipsIsaPkg::OP_LW, 5'd1, 5'd8, 16'h0004), '0);   // lw r8
        checkCount("lw stall cycles", 0, stallCycles);
        issue(1'b1, encodeR(5'd8, 5'd9, 5'd10, FN_ADD), '0);                // Reads r8
        checkCount("add stall cycles", 1, stallCycles);
        checkCount("add flush cycles", 0, flushCycles);
        idleSlot();
        checkCount("stallCount", baseStall + 1'b1, stallCount);
        endTest();
    endtask

    task automatic branchTest();
        beginTest("branch");
        idleSlot();
        issue(1'b1, encodeR(5'd1, 5'd2, 5'd9, FN_ADD), '0);                   // Writes r9
        // WB writing r3 blocks the compare while stalled
        issue(1'b1, encodeI(mipsIsaPkg::OP_BEQ, 5'd9, 5'd3, 16'h0010), 5'd3);
        checkCount("beq stall cycles", 1, stallCycles);
        checkBit("ready in stall", 1'b0, readyFirst);
        checkBit("ready after stall", 1'b1, readyLast);
        issue(1'b1, encodeI(mipsIsaPkg::OP_BEQ, 5'd4, 5'd5, 16'h0010), '0);  // No dependency
        checkCount("free beq stall cycles", 0, stallCycles);
        checkBit("free beq ready", 1'b1, readyFirst);
        issue(1'b1, encodeR(5'd1, 5'd2, 5'd9, FN_ADD), '0);
        // Unrelated WB register leaves the compare ready during the stall
        issue(1'b1, encodeI(mipsIsaPkg::OP_BNE, 5'd9, 5'd3, 16'h0010), 5'd12);
        checkCount("bne stall cycles", 1, stallCycles);
        checkBit("bne ready in stall", 1'b1, readyFirst);
        endTest();
    endtask

    task automatic jalJrTest();
        logic [`COUNT_W-1:0] baseStall;
        logic [`COUNT_W-1:0] baseFlush;
        beginTest("jalJr");
        idleSlot();
        baseStall = stallCount;
        baseFlush = flushCount;
        issue(1'b1, encodeI(mipsIsaPkg::OP_JAL, 5'd0, 5'd0, 16'h0040), '0);
        checkCount("jal flush cycles", 1, flushCycles);
        issue(1'b1, encodeR(5'd31, 5'd0, 5'd0, mipsIsaPkg::FN_JR), '0);      // jr r31
        checkCount("jr stall cycles", 2, stallCycles);
        checkCount("jr flush cycles", 3, flushCycles);   // Two stalls plus the jump
        issue(1'b1, encodeR(5'd1, 5'd2, 5'd5, FN_ADD), '0);                   // Writes r5
        issue(1'b1, encodeR(5'd5, 5'd0, 5'd0, mipsIsaPkg::FN_JR), '0);       // jr r5
        checkCount("jr r5 stall cycles", 2, stallCycles);   // EX then MEM hold the write
        checkCount("jr r5 flush cycles", 1, flushCycles);   // Source stalls do not flush
        idleSlot();
        checkCount("stallCount", baseStall + 2'd2, stallCount);
        checkCount("flushCount", baseFlush + 3'd5, flushCount);
        endTest();
    endtask

    task automatic plainJumpTest();
        logic [`COUNT_W-1:0] baseFlush;
        beginTest("jump");
        idleSlot();
        baseFlush = flushCount;
        issue(1'b1, encodeI(mipsIsaPkg::OP_J, 5'd0, 5'd0, 16'h0080), '0);
        checkCount("j stall cycles", 0, stallCycles);
        checkCount("j flush cycles", 1, flushCycles);
        checkBit("j ifIdWrite", 1'b0, ifIdLast);
        issue(1'b1, encodeI(mipsIsaPkg::OP_JAL, 5'd0, 5'd0, 16'h00c0), '0);
        checkCount("jal stall cycles", 0, stallCycles);
        checkCount("jal flush cycles", 1, flushCycles);
        checkBit("jal ifIdWrite", 1'b0, ifIdLast);
        idleSlot();
        checkCount("flushCount", baseFlush + 2'd2, flushCount);
        endTest();
    endtask

    task automatic invalidWordTest();
        logic [`COUNT_W-1:0] baseStall;
        logic [`COUNT_W-1:0] baseFlush;
        beginTest("invalid");
        idleSlot();
        baseStall = stallCount;
        baseFlush = flushCount;
        // JAL in EX would stall a valid jr r31
        issue(1'b1, encodeI(mipsIsaPkg::OP_JAL, 5'd0, 5'd0, 16'h0100), '0);
        issue(1'b0, encodeR(5'd31, 5'd0, 5'd0, mipsIsaPkg::FN_JR), '0);
        checkCount("jr stall cycles", 0, stallCycles);
        checkCount("jr flush cycles", 0, flushCycles);
        checkBit("jr ifIdWrite", 1'b1, ifIdLast);
        issue(1'b0, encodeI(mipsIsaPkg::OP_BEQ, 5'd4, 5'd5, 16'h0010), '0);
        checkBit("beq ready", 1'b0, readyFirst);
        checkBit("beq ifIdWrite", 1'b1, ifIdLast);
        idleSlot();
        checkCount("stallCount", baseStall, stallCount);
        checkCount("flushCount", baseFlush + 1'b1, flushCount);  // JAL only
        endTest();
    endtask

    // ------------------------------------------------------------------
    // Sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        rngState   = 32'h42fa0a45;
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        memWbDst   = '0;
        numTests   = 0;
        numChecks  = 0;
        numErrors  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        resetAluTest();
        loadUseTest();
        branchTest();
        jalJrTest();
        plainJumpTest();
        invalidWordTest();
        $display("Summary: %0d tests, %0d checks, %0d errors", numTests, numChecks, numErrors);
        if (numErrors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + TEST_CYCLES + MARGIN));
        $display("Watchdog expired before the tests completed");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mipsIsaPkg.sv
pipeCtrlPkg.sv
instrDecode.sv
destTracker.sv
hazardFsm.sv
stallCounter.sv
hazardTop.sv
tbHazard.sv

/* Bender.yml */
package:
  name: hazard_ctrl

sources:
  - include_dirs:
      - .
    files:
      - mipsIsaPkg.sv
      - pipeCtrlPkg.sv
      - instrDecode.sv
      - destTracker.sv
      - hazardFsm.sv
      - stallCounter.sv
      - hazardTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbHazard.sv
